// ==== verilog/csi2RxPkg.sv ====
// Shared constants for the CSI-2 byte-lane receive front end.
// Lane and FIFO word layout, FIFO sizing, packet header field widths
// and the short/long datatype boundary.

package csi2RxPkg;

	// ------------------------------------------------------------------------
	// D-PHY lane side
	// ------------------------------------------------------------------------
	localparam int lpLaneByteWidth   = 8;							// One HS lane byte

	// FIFO word is {sync, lane1, lane0}
	localparam int lpFifoWordWidth   = 2 * lpLaneByteWidth + 1;	// 17 bits
	localparam int lpFifoSyncBit     = 2 * lpLaneByteWidth;		// Sync flag on top

	// ------------------------------------------------------------------------
	// Clock crossing FIFO
	// ------------------------------------------------------------------------
	localparam int lpFifoDepth       = 16;						// Words, power of two
	localparam int lpFifoAlmostFull  = 2;						// Free entries at flag
	localparam int lpFifoAddrWidth   = $clog2(lpFifoDepth);		// Default depth only

	// ------------------------------------------------------------------------
	// Packet fields
	// ------------------------------------------------------------------------
	localparam int lpPixelWidth      = 2 * lpLaneByteWidth;		// Lane1:lane0
	localparam int lpDataTypeWidth   = 6;						// DataID low bits
	localparam int lpVcWidth         = 2;						// DataID top bits
	localparam int lpWordCountWidth  = 16;						// Payload bytes
	localparam int lpEccWidth        = 8;						// Header ECC

	// Datatypes up to and including this value are short packets
	localparam logic [lpDataTypeWidth-1:0] lpLongPacketMinDt = 6'h13;

	// Payload words per line, word count / 2
	localparam int lpLineCountWidth  = lpWordCountWidth - 1;

endpackage

// ==== verilog/resetSync.sv ====
// Reset synchronizer, one per clock domain.
// Asserts asynchronously with qnHsRst, releases on the second iClk edge.

`timescale 1ns/1ns

module resetSync (
	input  logic iClk,			// Destination clock
	input  logic qnHsRst,		// Shared async reset, active low
	output logic qnRst			// Synchronized reset, active low
);

	logic rnMeta;				// First stage

	always_ff @(posedge iClk or negedge qnHsRst)
	begin
		if (!qnHsRst)
		begin
			rnMeta <= 1'b0;
			qnRst  <= 1'b0;
		end
		else
		begin
			rnMeta <= 1'b1;			// Release ripples in
			qnRst  <= rnMeta;
		end
	end

endmodule

// ==== verilog/dphyByteCapture.sv ====
// Word-clock capture of the two HS lane bytes and the sync flag.
// Forms the FIFO write word {sync, lane1, lane0} one word clock after the PHY.

`timescale 1ns/1ns

module dphyByteCapture (
	input  logic                                 iWordClk,	// PHY byte clock
	input  logic                                 qnRst,		// Word-domain reset
	input  logic [csi2RxPkg::lpLaneByteWidth-1:0] iLane0Data,	// HS lane 0 byte
	input  logic [csi2RxPkg::lpLaneByteWidth-1:0] iLane1Data,	// HS lane 1 byte
	input  logic                                 iLane0Valid,	// HS data valid
	input  logic                                 iLane0Sync,	// HS sync observed
	output logic [csi2RxPkg::lpFifoWordWidth-1:0] wWrData,	// FIFO write word
	output logic                                 wWrEn		// FIFO write strobe
);

	import csi2RxPkg::*;

	logic [lpLaneByteWidth-1:0] rLane0;		// Lanes assumed aligned
	logic [lpLaneByteWidth-1:0] rLane1;
	logic                       rValid;
	logic                       rSync;

	// Bytes, sync word carries zeros
	always_ff @(posedge iWordClk)
	begin
		rLane0 <= iLane0Sync ? '0 : iLane0Data;
		rLane1 <= iLane0Sync ? '0 : iLane1Data;
	end

	always_ff @(posedge iWordClk or negedge qnRst)
	begin
		if (!qnRst)
		begin
			rValid <= 1'b0;
			rSync  <= 1'b0;
		end
		else
		begin
			rValid <= iLane0Valid;
			rSync  <= iLane0Sync;
		end
	end

	assign wWrData = {rSync, rLane1, rLane0};	// Sync flag on lpFifoSyncBit
	assign wWrEn   = rValid | rSync;			// Sync word also goes through

endmodule

// ==== verilog/dualClkFifo.sv ====
// Dual-clock FIFO carrying lane words from the word clock into iSCLK.
// Gray pointers cross through two-flop synchronizers; flags come from the
// synchronized pointers. Read data and read-valid follow a read by one cycle.

`timescale 1ns/1ns

module dualClkFifo #(
	parameter int pDepth = csi2RxPkg::lpFifoDepth				// Power of two, >= 4
) (
	// Write side
	input  logic                                 iWrClk,
	input  logic                                 qnWrRst,
	input  logic [csi2RxPkg::lpFifoWordWidth-1:0] iWrData,
	input  logic                                 iWrEn,
	output logic                                 oFull,
	output logic                                 oAlmostFull,
	// Read side
	input  logic                                 iSCLK,
	input  logic                                 qnRdRst,
	input  logic                                 iRdEn,
	output logic [csi2RxPkg::lpFifoWordWidth-1:0] oRdData,
	output logic                                 oRdValid,
	output logic                                 oEmpty
);

	import csi2RxPkg::*;

	localparam int lpAw = $clog2(pDepth);		// Pointers carry one extra wrap bit

	logic [lpFifoWordWidth-1:0] rMem [pDepth];

	logic [lpAw:0] rWrBin, rWrGray, wWrBinNext;
	logic [lpAw:0] rRdBin, rRdGray, wRdBinNext;
	logic [lpAw:0] rRdGraySync1, rRdGraySync2;	// Read pointer in write domain
	logic [lpAw:0] rWrGraySync1, rWrGraySync2;	// Write pointer in read domain
	logic [lpAw:0] wWrCount;
	logic          wWrHit, wRdHit;

	function automatic logic [lpAw:0] gray2Bin(input logic [lpAw:0] iGray);
		logic [lpAw:0] vBin;
		vBin[lpAw] = iGray[lpAw];
		for (int i = lpAw - 1; i >= 0; i--)
			vBin[i] = vBin[i+1] ^ iGray[i];
		return vBin;
	endfunction

	// ------------------------------------------------------------------------
	// Write domain
	// ------------------------------------------------------------------------
	assign wWrHit      = iWrEn & ~oFull;				// Overflow write dropped
	assign wWrBinNext  = rWrBin + {{lpAw{1'b0}}, wWrHit};
	assign wWrCount    = rWrBin - gray2Bin(rRdGraySync2);	// Pessimistic fill level
	assign oFull       = (wWrCount == (lpAw+1)'(pDepth));
	assign oAlmostFull = (wWrCount >= (lpAw+1)'(pDepth - lpFifoAlmostFull));

	always_ff @(posedge iWrClk)
	begin
		if (wWrHit)
			rMem[rWrBin[lpAw-1:0]] <= iWrData;
	end

	always_ff @(posedge iWrClk or negedge qnWrRst)
	begin
		if (!qnWrRst)
		begin
			rWrBin       <= '0;
			rWrGray      <= '0;
			rRdGraySync1 <= '0;
			rRdGraySync2 <= '0;
		end
		else
		begin
			rWrBin       <= wWrBinNext;
			rWrGray      <= wWrBinNext ^ (wWrBinNext >> 1);	// Bin to Gray
			rRdGraySync1 <= rRdGray;
			rRdGraySync2 <= rRdGraySync1;
		end
	end

	// ------------------------------------------------------------------------
	// Read domain
	// ------------------------------------------------------------------------
	assign oEmpty     = (rRdGray == rWrGraySync2);
	assign wRdHit     = iRdEn & ~oEmpty;
	assign wRdBinNext = rRdBin + {{lpAw{1'b0}}, wRdHit};

	always_ff @(posedge iSCLK)
	begin
		if (wRdHit)
			oRdData <= rMem[rRdBin[lpAw-1:0]];		// Held between reads
	end

	always_ff @(posedge iSCLK or negedge qnRdRst)
	begin
		if (!qnRdRst)
		begin
			rRdBin       <= '0;
			rRdGray      <= '0;
			rWrGraySync1 <= '0;
			rWrGraySync2 <= '0;
			oRdValid     <= 1'b0;
		end
		else
		begin
			rRdBin       <= wRdBinNext;
			rRdGray      <= wRdBinNext ^ (wRdBinNext >> 1);
			rWrGraySync1 <= rWrGray;
			rWrGraySync2 <= rWrGraySync1;
			oRdValid     <= wRdHit;				// Data valid next cycle
		end
	end

endmodule

// ==== verilog/csi2PacketParser.sv ====
// CSI-2 packet parser in the iSCLK domain.
// Finds the sync word, captures the two header words, drops short packets
// and forwards each long-packet payload word as one 16-bit pixel beat.

`timescale 1ns/1ns

module csi2PacketParser (
	input  logic                                  iSCLK,
	input  logic                                  qnRst,		// System-domain reset
	input  logic                                  iReady,		// Read permission
	input  logic [csi2RxPkg::lpFifoWordWidth-1:0]  iRdData,
	input  logic                                  iRdValid,
	input  logic                                  iEmpty,
	output logic                                  oRdEn,
	output logic [csi2RxPkg::lpPixelWidth-1:0]     oPixel,
	output logic [csi2RxPkg::lpDataTypeWidth-1:0]  oDataType,
	output logic [csi2RxPkg::lpVcWidth-1:0]        oVc,
	output logic [csi2RxPkg::lpWordCountWidth-1:0] oWordCount,
	output logic [csi2RxPkg::lpEccWidth-1:0]       oEcc,
	output logic                                  oValid
);

	import csi2RxPkg::*;

	typedef enum logic [2:0] {
		stIdle,			// Wait for sync word
		stHdr1,			// DataID, word count LSB
		stHdr2,			// Word count MSB, ECC
		stFilter,		// Short or empty packets dropped
		stPayload		// Pixel words
	} tState;

	tState                       rState;
	logic [lpLineCountWidth-1:0] rLineCnt;		// Payload words seen
	logic [lpLineCountWidth-1:0] wHalfCnt;		// Word count / 2
	logic                        wSyncWord;
	logic                        wLongPkt;
	logic                        wBeat;
	logic                        wLastBeat;

	assign oRdEn     = ~iEmpty & iReady;
	assign wSyncWord = iRdValid & iRdData[lpFifoSyncBit];
	assign wHalfCnt  = oWordCount[lpWordCountWidth-1:1];	// Odd counts unsupported
	assign wLongPkt  = (oDataType > lpLongPacketMinDt) && (wHalfCnt != '0);

	// First payload word may already arrive in the filter cycle
	assign wBeat     = iRdValid & ((rState == stPayload) | ((rState == stFilter) & wLongPkt));
	assign wLastBeat = wBeat & (rLineCnt == wHalfCnt - 1'b1);

	// ------------------------------------------------------------------------
	// State machine
	// ------------------------------------------------------------------------
	always_ff @(posedge iSCLK or negedge qnRst)
	begin
		if (!qnRst)
			rState <= stIdle;
		else
		begin
			case (rState)
				stIdle:		if (wSyncWord) rState <= stHdr1;
				stHdr1:		if (iRdValid)  rState <= stHdr2;
				stHdr2:		if (iRdValid)  rState <= stFilter;
				stFilter:
				begin
					if (wLongPkt)
						rState <= wLastBeat ? stIdle : stPayload;
					else
						rState <= wSyncWord ? stHdr1 : stIdle;	// Back-to-back sync
				end
				stPayload:	if (wLastBeat) rState <= stIdle;
				default:	rState <= stIdle;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Header registers and payload counter
	// ------------------------------------------------------------------------
	always_ff @(posedge iSCLK or negedge qnRst)
	begin
		if (!qnRst)
		begin
			oDataType  <= '0;
			oVc        <= '0;
			oWordCount <= '0;
			oEcc       <= '0;
			oValid     <= 1'b0;
			rLineCnt   <= '0;
		end
		else
		begin
			if (rState == stHdr1 && iRdValid)
			begin
				oDataType             <= iRdData[lpDataTypeWidth-1:0];		// Lane 0
				oVc                   <= iRdData[lpLaneByteWidth-1 -: lpVcWidth];
				oWordCount[7:0]       <= iRdData[lpFifoSyncBit-1 -: lpLaneByteWidth];
			end
			if (rState == stHdr2 && iRdValid)
			begin
				oWordCount[15:8]      <= iRdData[lpLaneByteWidth-1:0];		// MSB on lane 0
				oEcc                  <= iRdData[lpFifoSyncBit-1 -: lpEccWidth];
			end
			oValid <= wBeat;					// One cycle per word

			if (wLastBeat)
				rLineCnt <= '0;
			else if (wBeat)
				rLineCnt <= rLineCnt + 1'b1;
		end
	end

	// Pixel is {lane1, lane0}, held until the next beat
	always_ff @(posedge iSCLK)
	begin
		if (wBeat)
			oPixel <= iRdData[lpPixelWidth-1:0];
	end

endmodule

// ==== verilog/csi2RxDecoder.sv ====
// Top level of the CSI-2 two-lane receive front end.
// Lane bytes are captured on iWordClk, cross the FIFO into iSCLK and are
// parsed into header fields and 16-bit pixel beats.

`timescale 1ns/1ns

module csi2RxDecoder (
	// Word-clock domain
	input  logic                                  iWordClk,
	input  logic [csi2RxPkg::lpLaneByteWidth-1:0]  iLane0Data,
	input  logic [csi2RxPkg::lpLaneByteWidth-1:0]  iLane1Data,
	input  logic                                  iLane0Valid,
	input  logic                                  iLane0Sync,
	// System domain
	input  logic                                  iSCLK,
	input  logic                                  iReady,
	output logic [csi2RxPkg::lpPixelWidth-1:0]     oPixel,
	output logic [csi2RxPkg::lpDataTypeWidth-1:0]  oDataType,
	output logic [csi2RxPkg::lpVcWidth-1:0]        oVc,
	output logic [csi2RxPkg::lpWordCountWidth-1:0] oWordCount,
	output logic [csi2RxPkg::lpEccWidth-1:0]       oEcc,
	output logic                                  oValid,
	output logic                                  oFifoFull,	// Almost full, 2 left
	// Shared reset
	input  logic                                  qnHsRst
);

	import csi2RxPkg::*;

	logic                       qnWordRst, qnSysRst;		// Per-domain resets
	logic [lpFifoWordWidth-1:0] wWrData, wRdData;
	logic                       wWrEn, wRdEn, wRdValid, wEmpty;

	resetSync resetSyncWord_i (.iClk(iWordClk), .qnHsRst(qnHsRst), .qnRst(qnWordRst));
	resetSync resetSyncSys_i  (.iClk(iSCLK),    .qnHsRst(qnHsRst), .qnRst(qnSysRst));

	dphyByteCapture dphyByteCapture_i (
		.iWordClk(iWordClk),	.qnRst(qnWordRst),
		.iLane0Data(iLane0Data),	.iLane1Data(iLane1Data),
		.iLane0Valid(iLane0Valid),	.iLane0Sync(iLane0Sync),
		.wWrData(wWrData),		.wWrEn(wWrEn)
	);

	// Hard full is left open, the PHY cannot stall
	dualClkFifo #(.pDepth(lpFifoDepth)) dualClkFifo_i (
		.iWrClk(iWordClk),	.qnWrRst(qnWordRst),
		.iWrData(wWrData),	.iWrEn(wWrEn),
		.oFull(),			.oAlmostFull(oFifoFull),
		.iSCLK(iSCLK),		.qnRdRst(qnSysRst),
		.iRdEn(wRdEn),		.oRdData(wRdData),
		.oRdValid(wRdValid),	.oEmpty(wEmpty)
	);

	csi2PacketParser csi2PacketParser_i (
		.iSCLK(iSCLK),		.qnRst(qnSysRst),		.iReady(iReady),
		.iRdData(wRdData),	.iRdValid(wRdValid),	.iEmpty(wEmpty),
		.oRdEn(wRdEn),		.oPixel(oPixel),
		.oDataType(oDataType),	.oVc(oVc),
		.oWordCount(oWordCount),	.oEcc(oEcc),	.oValid(oValid)
	);

endmodule

// ==== verif/dualClkFifo_assert.sv ====
// Protocol assertions for the dual-clock FIFO, bound into every instance.
// Covers overflow, underflow and the one-cycle read-valid timing.

`timescale 1ns/1ns

module dualClkFifo_assert (
	input logic iWrClk,
	input logic qnWrRst,
	input logic iWrEn,
	input logic oFull,
	input logic iSCLK,
	input logic qnRdRst,
	input logic iRdEn,
	input logic oEmpty,
	input logic oRdValid
);

	// Write side, PHY cannot stall
	noWriteWhenFull: assert property (@(posedge iWrClk) disable iff (!qnWrRst)
		!(iWrEn && oFull)) else $error("FIFO written while full");

	// Read side
	noReadWhenEmpty: assert property (@(posedge iSCLK) disable iff (!qnRdRst)
		!(iRdEn && oEmpty)) else $error("FIFO read while empty");

	validAfterRead: assert property (@(posedge iSCLK) disable iff (!qnRdRst)
		oRdValid |-> $past(iRdEn && !oEmpty)) else $error("Read-valid without a read");

endmodule

bind dualClkFifo dualClkFifo_assert dualClkFifoAssert_i (
	.iWrClk(iWrClk),	.qnWrRst(qnWrRst),	.iWrEn(iWrEn),	.oFull(oFull),
	.iSCLK(iSCLK),		.qnRdRst(qnRdRst),	.iRdEn(iRdEn),	.oEmpty(oEmpty),
	.oRdValid(oRdValid)
);

// ==== verif/csi2RxDecoderTb.sv ====
// Testbench for the CSI-2 two-lane receive front end.
// LFSR-driven packets go out on the lanes, a queue model holds the expected beats
// and headers, and iReady is toggled at random or held low to force back-pressure.

`timescale 1ns/1ns

module csi2RxDecoderTb;

	import csi2RxPkg::*;

	localparam int          lpWaitLimit = 4000;			// Cycles allowed per wait loop
	localparam logic [31:0] lpSeed      = 32'heda612cb;

	logic                        iWordClk, iSCLK, qnHsRst, iReady;
	logic [lpLaneByteWidth-1:0]  iLane0Data, iLane1Data;
	logic                        iLane0Valid, iLane0Sync;
	logic [lpPixelWidth-1:0]     oPixel;
	logic [lpDataTypeWidth-1:0]  oDataType;
	logic [lpVcWidth-1:0]        oVc;
	logic [lpWordCountWidth-1:0] oWordCount;
	logic [lpEccWidth-1:0]       oEcc;
	logic                        oValid, oFifoFull;

	logic [31:0] phyLfsr, rdyLfsr;			// Separate streams per clock domain
	logic [15:0] expPix [$];				// Model, one entry per beat
	logic [31:0] expHdr [$];				// {vc, dt, wc, ecc} per beat
	logic [31:0] chkHdr;
	logic [1:0]  rdyHist;					// iReady seen on the last two negedges
	logic        stallMode, sawFull;

	csi2RxDecoder csi2RxDecoder_i (.*);

	initial
	begin
		iSCLK = 1'b0;
		forever #20 iSCLK = ~iSCLK;			// 40 ns
	end

	initial
	begin
		iWordClk = 1'b0;
		forever #14 iWordClk = ~iWordClk;	// 28 ns, unrelated to iSCLK
	end

	// Galois LFSR, x^32 + x^31 + x^29 + x + 1
	function automatic logic [31:0] galoisStep(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'hD0000001 : 32'h0);
	endfunction

	task automatic takeBits(inout logic [31:0] st, input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v  = {v[30:0], st[0]};			// One step per bit
			st = galoisStep(st);
		end
	endtask

	task automatic failNow(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic checkEq(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
			failNow($sformatf("FAIL %s: expected 0x%0h, actual 0x%0h", name, exp, act));
	endtask

	task automatic driveIdle(input int n);
		repeat (n)
		begin
			@(posedge iWordClk);
			#2;
			iLane0Valid = 1'b0;
			iLane0Sync  = 1'b0;
		end
	endtask

	// One lane word; PHY idles while the FIFO reports almost full
	task automatic driveWord(input logic s, input logic v,
		input logic [7:0] b0, input logic [7:0] b1);
		int waitCnt;
		waitCnt = 0;
		@(posedge iWordClk);
		#2;
		while (oFifoFull)
		begin
			sawFull     = 1'b1;
			iLane0Valid = 1'b0;
			iLane0Sync  = 1'b0;
			waitCnt++;
			if (waitCnt > lpWaitLimit)
				failNow("PHY held off by oFifoFull for too long, FIFO is not draining");
			@(posedge iWordClk);
			#2;
		end
		iLane0Sync  = s;
		iLane0Valid = v;
		iLane0Data  = b0;
		iLane1Data  = b1;
	endtask

	task automatic sendPacket(input logic forceLong);
		logic [31:0] r, vc, dt, wc, ecc, b;
		logic [15:0] pix [$];
		logic        isLong;
		takeBits(phyLfsr, 2, vc);
		takeBits(phyLfsr, 2, r);
		isLong = forceLong || (r != 0);				// About 1 in 4 short
		if (isLong)
		begin
			takeBits(phyLfsr, 6, r);
			dt = 32'h18 + r % 40;					// 0x18 to 0x3F
			takeBits(phyLfsr, 5, r);
			wc = forceLong ? 64 : (r + 1) * 2;		// Even, 2 to 64
		end
		else
		begin
			takeBits(phyLfsr, 5, r);
			dt = r % 20;							// 0x00 to 0x13
			takeBits(phyLfsr, 16, wc);				// Short packet data field
		end
		takeBits(phyLfsr, 8, ecc);
		if (isLong)
			for (int i = 0; i < wc / 2; i++)
			begin
				takeBits(phyLfsr, 16, b);
				pix.push_back(b[15:0]);
				expPix.push_back(b[15:0]);			// {lane1, lane0}
				expHdr.push_back({vc[1:0], dt[5:0], wc[15:0], ecc[7:0]});
			end
		driveWord(1'b1, 1'b0, 8'h00, 8'h00);		// Sync
		driveWord(1'b0, 1'b1, {vc[1:0], dt[5:0]}, wc[7:0]);
		driveWord(1'b0, 1'b1, wc[15:8], ecc[7:0]);
		foreach (pix[i])
			driveWord(1'b0, 1'b1, pix[i][7:0], pix[i][15:8]);
		takeBits(phyLfsr, 3, r);
		driveIdle(r);								// Zero gap gives back-to-back
	endtask

	// ------------------------------------------------------------------------
	// iReady, random or held low during the stall phase
	// ------------------------------------------------------------------------
	initial
	begin : readyDriver
		logic [31:0] r;
		int          holdCnt, stallCnt;
		holdCnt  = 0;
		stallCnt = 0;
		forever
		begin
			@(posedge iSCLK);
			#2;
			if (!qnHsRst)
				iReady = 1'b0;
			else if (stallMode)
			begin
				iReady = 1'b0;
				stallCnt++;
				if (sawFull)
					holdCnt++;						// Keep pressure on a while
				if (holdCnt == 40)
					stallMode = 1'b0;
				else if (stallCnt > lpWaitLimit)
					failNow("oFifoFull did not rise while iReady was held low");
			end
			else
			begin
				takeBits(rdyLfsr, 2, r);
				iReady = (r != 0);					// High 3 of 4 cycles
			end
		end
	end

	// ------------------------------------------------------------------------
	// Beat checker, samples away from the rising edge
	// ------------------------------------------------------------------------
	initial
	forever
	begin
		@(negedge iSCLK);
		if (oValid)
		begin
			if (expPix.size() == 0)
				failNow("Pixel beat seen with no payload word outstanding");
			checkEq("beat without read permission", 1, rdyHist[1]);	// Read two cycles back
			chkHdr = expHdr.pop_front();
			checkEq("oPixel", expPix.pop_front(), oPixel);
			checkEq("oVc", chkHdr[31:30], oVc);
			checkEq("oDataType", chkHdr[29:24], oDataType);
			checkEq("oWordCount", chkHdr[23:8], oWordCount);
			checkEq("oEcc", chkHdr[7:0], oEcc);
		end
		rdyHist = {rdyHist[0], iReady};
	end

	initial
	begin : mainSeq
		int waitCnt;
		qnHsRst     = 1'b0;
		iReady      = 1'b0;
		iLane0Data  = '0;
		iLane1Data  = '0;
		iLane0Valid = 1'b0;
		iLane0Sync  = 1'b0;
		phyLfsr     = lpSeed;
		rdyLfsr     = lpSeed;
		rdyHist     = '0;
		stallMode   = 1'b0;
		sawFull     = 1'b0;
		repeat (8) @(posedge iSCLK);
		#2 qnHsRst = 1'b1;
		repeat (4) @(posedge iSCLK);
		@(negedge iSCLK);							// Outputs settled

		checkEq("oValid after reset", 0, oValid);		// Before any packet
		checkEq("oFifoFull after reset", 0, oFifoFull);
		checkEq("oDataType after reset", 0, oDataType);
		checkEq("oVc after reset", 0, oVc);
		checkEq("oWordCount after reset", 0, oWordCount);
		checkEq("oEcc after reset", 0, oEcc);

		repeat (30) sendPacket(1'b0);
		sawFull   = 1'b0;
		stallMode = 1'b1;						// Reads stop, FIFO must fill
		repeat (3) sendPacket(1'b1);
		repeat (20) sendPacket(1'b0);
		driveIdle(4);

		waitCnt = 0;
		while (expPix.size() != 0)
		begin
			@(posedge iSCLK);
			waitCnt++;
			if (waitCnt > lpWaitLimit)
				failNow($sformatf("Timeout with %0d pixel beats still missing", expPix.size()));
		end
		repeat (20) @(posedge iSCLK);			// Catch stray beats

		if (!sawFull)
			failNow("oFifoFull never rose while iReady was held low");
		else
		begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

// ==== filelist.f ====
verilog/csi2RxPkg.sv
verilog/resetSync.sv
verilog/dphyByteCapture.sv
verilog/dualClkFifo.sv
verilog/csi2PacketParser.sv
verilog/csi2RxDecoder.sv
verif/dualClkFifo_assert.sv
verif/csi2RxDecoderTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the CSI-2 receive testbench with Verilator and runs it.
# Exit status is zero only when the run reports the pass message.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module csi2RxDecoderTb -Mdir obj_dir -f filelist.f; then
	echo "Verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/Vcsi2RxDecoderTb 2>&1)
simStatus=$?
echo "$simOut"

if [ "$simStatus" -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -q "All tests passed"; then
	exit 0
fi
exit 1
